// ==== gmm_pkg.sv ====
package gmm_pkg;

   // --------------------------------------------------------------------
   // congestion side sizes
   // --------------------------------------------------------------------

   // egress ports tracked by the occupancy counters
   localparam int num_ports = 4;
   localparam int port_w    = 2;

   // pod count carried by a tag or a dequeue
   localparam int len_w     = 4;

   // per-port counter, saturating
   localparam int cnt_w     = 8;
   localparam int cnt_max   = 255;

   // sum of all port counters, 4 x 255 fits in 10 bits
   localparam int tot_w     = 10;

   // rx watermark hysteresis band, per port
   localparam int wm_hi     = 48;
   localparam int wm_lo     = 32;

   // shared memory watermark on the total
   localparam int sm_wm     = 128;

   // --------------------------------------------------------------------
   // pod pointer side sizes
   // --------------------------------------------------------------------

   // pods in the shared buffer, a power of two so list pointers wrap
   localparam int num_pods  = 32;
   localparam int pod_w     = 5;

   // fill count has to reach num_pods itself
   localparam int fl_cnt_w  = 6;

   // pod ring control states
   localparam logic [1:0] st_init = 2'd0;
   localparam logic [1:0] st_run  = 2'd1;

endpackage

// ==== gmm_free_list.sv ====
`timescale 1ns/1ps

module gmm_free_list (
   input  logic                         cclk,
   input  logic                         rst_n,
   input  logic                         push,
   input  logic [gmm_pkg::pod_w-1:0]    push_ptr,
   input  logic                         pop,
   output logic [gmm_pkg::pod_w-1:0]    head,
   output logic                         empty,
   output logic                         full,
   output logic [gmm_pkg::fl_cnt_w-1:0] count
);
   import gmm_pkg::*;

   // one slot per pod, the list can never hold more than every pod
   logic [pod_w-1:0] mem [num_pods];

   // read and write pointers wrap on their own width
   logic [pod_w-1:0] wr_ptr;
   logic [pod_w-1:0] rd_ptr;

   // --------------------------------------------------------------------
   // storage
   // --------------------------------------------------------------------

   always_ff @(posedge cclk) begin
      if (push) begin
         mem[wr_ptr] <= push_ptr;
      end
   end

   // --------------------------------------------------------------------
   // pointers and fill count
   // --------------------------------------------------------------------

   always_ff @(posedge cclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // oldest entry shows without a pop
   assign head  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == fl_cnt_w'(num_pods));

endmodule

// ==== gmm_pod_ring_fsm.sv ====
`timescale 1ns/1ps

module gmm_pod_ring_fsm (
   input  logic                      cclk,
   input  logic                      rst_n,
   input  logic                      ring_in_valid,
   input  logic                      ring_in_dirty,
   input  logic [gmm_pkg::pod_w-1:0] ring_in_ptr,
   output logic                      ring_out_valid,
   output logic                      ring_out_dirty,
   output logic [gmm_pkg::pod_w-1:0] ring_out_ptr,
   output logic                      stall,
   output logic                      fl_push,
   output logic [gmm_pkg::pod_w-1:0] fl_push_ptr,
   output logic                      fl_pop,
   input  logic [gmm_pkg::pod_w-1:0] fl_head,
   input  logic                      fl_empty,
   input  logic                      fl_full
);
   import gmm_pkg::*;

   logic [1:0]       state;
   logic [1:0]       state_nxt;
   logic [pod_w-1:0] init_ptr;
   logic             init_last;

   // slot leaving this cycle, before the output flop
   logic             nxt_valid;
   logic             nxt_dirty;
   logic [pod_w-1:0] nxt_ptr;

   // --------------------------------------------------------------------
   // init / run control
   // --------------------------------------------------------------------

   assign init_last = (init_ptr == pod_w'(num_pods - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         st_init: if (init_last) state_nxt = st_run;
         st_run:  state_nxt = st_run;
         default: state_nxt = st_init;
      endcase
   end

   always_ff @(posedge cclk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_init;
         init_ptr <= '0;
      end else begin
         state <= state_nxt;
         // walks 0 .. num_pods-1, one free pod per cycle
         if (state == st_init) begin
            init_ptr <= init_ptr + 1'b1;
         end
      end
   end

   // --------------------------------------------------------------------
   // per-slot decision
   // --------------------------------------------------------------------

   always_comb begin
      fl_push     = 1'b0;
      fl_push_ptr = init_ptr;
      fl_pop      = 1'b0;
      // default is pass through
      nxt_valid   = ring_in_valid;
      nxt_dirty   = ring_in_dirty;
      nxt_ptr     = ring_in_ptr;
      case (state)
         st_init: begin
            // load list, ring slots just pass
            fl_push = 1'b1;
         end
         st_run: begin
            if (ring_in_valid && ring_in_dirty && !fl_full) begin
               // absorb dirty pod, slot leaves empty
               fl_push     = 1'b1;
               fl_push_ptr = ring_in_ptr;
               nxt_valid   = 1'b0;
               nxt_dirty   = 1'b0;
               nxt_ptr     = '0;
            end else if (!ring_in_valid && !fl_empty) begin
               // fill empty slot with a clean pod
               fl_pop    = 1'b1;
               nxt_valid = 1'b1;
               nxt_dirty = 1'b0;
               nxt_ptr   = fl_head;
            end
         end
         default: ;
      endcase
   end

   // --------------------------------------------------------------------
   // outgoing slot and stall
   // --------------------------------------------------------------------

   always_ff @(posedge cclk or negedge rst_n) begin
      if (!rst_n) begin
         ring_out_valid <= 1'b0;
         ring_out_dirty <= 1'b0;
         stall          <= 1'b1;
      end else begin
         ring_out_valid <= nxt_valid;
         ring_out_dirty <= nxt_dirty;
         // egress holds off dirty pods while list cannot take them
         stall          <= (state == st_init) || fl_full;
      end
   end

   always_ff @(posedge cclk) begin
      ring_out_ptr <= nxt_ptr;
   end

endmodule

// ==== gmm_occupancy_counter.sv ====
`timescale 1ns/1ps

module gmm_occupancy_counter (
   input  logic                       cclk,
   input  logic                       rst_n,
   input  logic                       tag_in_valid,
   input  logic [gmm_pkg::port_w-1:0] tag_in_port,
   input  logic [gmm_pkg::len_w-1:0]  tag_in_len,
   input  logic                       deq_valid,
   input  logic [gmm_pkg::port_w-1:0] deq_port,
   input  logic [gmm_pkg::len_w-1:0]  deq_len,
   output logic                       tag_out_valid,
   output logic [gmm_pkg::port_w-1:0] tag_out_port,
   output logic [gmm_pkg::len_w-1:0]  tag_out_len,
   output logic [gmm_pkg::cnt_w-1:0]  port_cnt [gmm_pkg::num_ports],
   output logic [gmm_pkg::tot_w-1:0]  total_cnt
);
   import gmm_pkg::*;

   logic [cnt_w-1:0] cnt_nxt [num_ports];
   logic [tot_w-1:0] total_nxt;

   // --------------------------------------------------------------------
   // tag ring repeater toward egress
   // --------------------------------------------------------------------

   always_ff @(posedge cclk or negedge rst_n) begin
      if (!rst_n) begin
         tag_out_valid <= 1'b0;
      end else begin
         tag_out_valid <= tag_in_valid;
      end
   end

   always_ff @(posedge cclk) begin
      tag_out_port <= tag_in_port;
      tag_out_len  <= tag_in_len;
   end

   // --------------------------------------------------------------------
   // per-port saturating counters
   // --------------------------------------------------------------------

   always_comb begin
      logic [cnt_w:0] add;
      logic [cnt_w:0] sub;
      logic [cnt_w:0] up;
      logic [cnt_w:0] diff;
      total_nxt = '0;
      for (int p = 0; p < num_ports; p++) begin
         add = '0;
         sub = '0;
         if (tag_in_valid && tag_in_port == port_w'(p)) begin
            add[len_w-1:0] = tag_in_len;
         end
         if (deq_valid && deq_port == port_w'(p)) begin
            sub[len_w-1:0] = deq_len;
         end
         // one spare bit keeps the carry for the top clamp
         up   = {1'b0, port_cnt[p]} + add;
         diff = up - sub;
         if (up < sub) begin
            cnt_nxt[p] = '0;
         end else if (diff > (cnt_w + 1)'(cnt_max)) begin
            cnt_nxt[p] = cnt_w'(cnt_max);
         end else begin
            cnt_nxt[p] = diff[cnt_w-1:0];
         end
         // total follows the clamped values
         total_nxt = total_nxt + tot_w'(cnt_nxt[p]);
      end
   end

   always_ff @(posedge cclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int p = 0; p < num_ports; p++) begin
            port_cnt[p] <= '0;
         end
         total_cnt <= '0;
      end else begin
         for (int p = 0; p < num_ports; p++) begin
            port_cnt[p] <= cnt_nxt[p];
         end
         total_cnt <= total_nxt;
      end
   end

endmodule

// ==== gmm_watermark_cmp.sv ====
`timescale 1ns/1ps

module gmm_watermark_cmp (
   input  logic                         cclk,
   input  logic                         rst_n,
   input  logic [gmm_pkg::cnt_w-1:0]    port_cnt [gmm_pkg::num_ports],
   input  logic [gmm_pkg::tot_w-1:0]    total_cnt,
   output logic [gmm_pkg::num_ports-1:0] rx_wm,
   output logic                         sm_wm
);
   import gmm_pkg::*;

   logic [num_ports-1:0] rx_wm_nxt;
   logic                 sm_wm_nxt;

   // --------------------------------------------------------------------
   // rx watermark with hysteresis
   // --------------------------------------------------------------------

   always_comb begin
      for (int p = 0; p < num_ports; p++) begin
         // hold inside the band
         rx_wm_nxt[p] = rx_wm[p];
         if (port_cnt[p] >= cnt_w'(wm_hi)) begin
            rx_wm_nxt[p] = 1'b1;
         end else if (port_cnt[p] <= cnt_w'(wm_lo)) begin
            rx_wm_nxt[p] = 1'b0;
         end
      end
   end

   // --------------------------------------------------------------------
   // shared memory watermark
   // --------------------------------------------------------------------

   // the output port hides the package name here
   assign sm_wm_nxt = (total_cnt >= tot_w'(gmm_pkg::sm_wm));

   always_ff @(posedge cclk or negedge rst_n) begin
      if (!rst_n) begin
         rx_wm <= '0;
         sm_wm <= 1'b0;
      end else begin
         rx_wm <= rx_wm_nxt;
         sm_wm <= sm_wm_nxt;
      end
   end

endmodule

// ==== gmm_top.sv ====
`timescale 1ns/1ps

module gmm_top (
   input  logic                          cclk,
   input  logic                          rst_n,
   // pod pointer ring
   input  logic                          pod_ring_in_valid,
   input  logic                          pod_ring_in_dirty,
   input  logic [gmm_pkg::pod_w-1:0]     pod_ring_in_ptr,
   output logic                          pod_ring_out_valid,
   output logic                          pod_ring_out_dirty,
   output logic [gmm_pkg::pod_w-1:0]     pod_ring_out_ptr,
   output logic                          pod_ring_stall,
   // tag ring, ingress to egress
   input  logic                          tag_in_valid,
   input  logic [gmm_pkg::port_w-1:0]    tag_in_port,
   input  logic [gmm_pkg::len_w-1:0]     tag_in_len,
   output logic                          tag_out_valid,
   output logic [gmm_pkg::port_w-1:0]    tag_out_port,
   output logic [gmm_pkg::len_w-1:0]     tag_out_len,
   // egress dequeue
   input  logic                          deq_valid,
   input  logic [gmm_pkg::port_w-1:0]    deq_port,
   input  logic [gmm_pkg::len_w-1:0]     deq_len,
   // congestion watermarks
   output logic [gmm_pkg::num_ports-1:0] rx_wm,
   output logic                          sm_wm
);
   import gmm_pkg::*;

   // fsm <-> free list
   logic             fl_push;
   logic [pod_w-1:0] fl_push_ptr;
   logic             fl_pop;
   logic [pod_w-1:0] fl_head;
   logic             fl_empty;
   logic             fl_full;

   // counters -> watermark compare
   logic [cnt_w-1:0] port_cnt [num_ports];
   logic [tot_w-1:0] total_cnt;

   // --------------------------------------------------------------------
   // pod pointer management
   // --------------------------------------------------------------------

   gmm_pod_ring_fsm u_pod_ring_fsm (
      .cclk           (cclk),
      .rst_n          (rst_n),
      .ring_in_valid  (pod_ring_in_valid),
      .ring_in_dirty  (pod_ring_in_dirty),
      .ring_in_ptr    (pod_ring_in_ptr),
      .ring_out_valid (pod_ring_out_valid),
      .ring_out_dirty (pod_ring_out_dirty),
      .ring_out_ptr   (pod_ring_out_ptr),
      .stall          (pod_ring_stall),
      .fl_push        (fl_push),
      .fl_push_ptr    (fl_push_ptr),
      .fl_pop         (fl_pop),
      .fl_head        (fl_head),
      .fl_empty       (fl_empty),
      .fl_full        (fl_full)
   );

   // fill count is for debug visibility only
   gmm_free_list u_free_list (
      .cclk     (cclk),
      .rst_n    (rst_n),
      .push     (fl_push),
      .push_ptr (fl_push_ptr),
      .pop      (fl_pop),
      .head     (fl_head),
      .empty    (fl_empty),
      .full     (fl_full),
      .count    ()
   );

   // --------------------------------------------------------------------
   // congestion management
   // --------------------------------------------------------------------

   gmm_occupancy_counter u_occupancy_counter (
      .cclk          (cclk),
      .rst_n         (rst_n),
      .tag_in_valid  (tag_in_valid),
      .tag_in_port   (tag_in_port),
      .tag_in_len    (tag_in_len),
      .deq_valid     (deq_valid),
      .deq_port      (deq_port),
      .deq_len       (deq_len),
      .tag_out_valid (tag_out_valid),
      .tag_out_port  (tag_out_port),
      .tag_out_len   (tag_out_len),
      .port_cnt      (port_cnt),
      .total_cnt     (total_cnt)
   );

   gmm_watermark_cmp u_watermark_cmp (
      .cclk      (cclk),
      .rst_n     (rst_n),
      .port_cnt  (port_cnt),
      .total_cnt (total_cnt),
      .rx_wm     (rx_wm),
      .sm_wm     (sm_wm)
   );

endmodule

// ==== tb_gmm_top.sv ====
`timescale 1ns/1ps

module tb_gmm_top;
   import gmm_pkg::*;

   // one table row: ring slot, tag, dequeue
   localparam int row_w = 2 + pod_w + 2 * (1 + port_w + len_w);

   logic                 cclk;
   logic                 rst_n;
   logic                 pod_ring_in_valid;
   logic                 pod_ring_in_dirty;
   logic [pod_w-1:0]     pod_ring_in_ptr;
   logic                 pod_ring_out_valid;
   logic                 pod_ring_out_dirty;
   logic [pod_w-1:0]     pod_ring_out_ptr;
   logic                 pod_ring_stall;
   logic                 tag_in_valid;
   logic [port_w-1:0]    tag_in_port;
   logic [len_w-1:0]     tag_in_len;
   logic                 tag_out_valid;
   logic [port_w-1:0]    tag_out_port;
   logic [len_w-1:0]     tag_out_len;
   logic                 deq_valid;
   logic [port_w-1:0]    deq_port;
   logic [len_w-1:0]     deq_len;
   logic [num_ports-1:0] rx_wm;
   logic                 sm_wm;

   // reference model state, mirrors every DUT register
   int                   fl_q[$];
   bit                   in_init;
   int                   init_ptr;
   logic                 m_rv;
   logic                 m_rd;
   logic [pod_w-1:0]     m_rp;
   logic                 m_stall;
   logic                 m_tv;
   logic [port_w-1:0]    m_tp;
   logic [len_w-1:0]     m_tl;
   int                   m_cnt[num_ports];
   int                   m_tot;
   logic [num_ports-1:0] m_rx;
   logic                 m_sm;

   string                row_name[$];
   logic [row_w-1:0]     row_word[$];
   int                   errors = 0;
   int                   checks = 0;
   int                   seed = 32'h4c33_4397;

   gmm_top DUT (
      .cclk               (cclk),
      .rst_n              (rst_n),
      .pod_ring_in_valid  (pod_ring_in_valid),
      .pod_ring_in_dirty  (pod_ring_in_dirty),
      .pod_ring_in_ptr    (pod_ring_in_ptr),
      .pod_ring_out_valid (pod_ring_out_valid),
      .pod_ring_out_dirty (pod_ring_out_dirty),
      .pod_ring_out_ptr   (pod_ring_out_ptr),
      .pod_ring_stall     (pod_ring_stall),
      .tag_in_valid       (tag_in_valid),
      .tag_in_port        (tag_in_port),
      .tag_in_len         (tag_in_len),
      .tag_out_valid      (tag_out_valid),
      .tag_out_port       (tag_out_port),
      .tag_out_len        (tag_out_len),
      .deq_valid          (deq_valid),
      .deq_port           (deq_port),
      .deq_len            (deq_len),
      .rx_wm              (rx_wm),
      .sm_wm              (sm_wm)
   );

   initial begin
      cclk = 1'b0;
      forever #4 cclk = ~cclk;
   end

   // ----------------------------------------------------------------------
   // table helpers
   // ----------------------------------------------------------------------

   function automatic logic [row_w-1:0] pack_row(input int rv, input int rd, input int rp,
                                                 input int tv, input int tp, input int tl,
                                                 input int dv, input int dp, input int dl);
      return {1'(rv), 1'(rd), pod_w'(rp), 1'(tv), port_w'(tp), len_w'(tl),
              1'(dv), port_w'(dp), len_w'(dl)};
   endfunction

   task automatic add_row(input string name, input logic [row_w-1:0] w);
      row_name.push_back(name);
      row_word.push_back(w);
   endtask

   // ----------------------------------------------------------------------
   // reference model, one call per rising edge
   // ----------------------------------------------------------------------

   task automatic model_reset();
      fl_q.delete();
      in_init  = 1'b1;
      init_ptr = 0;
      m_rv     = 1'b0;
      m_rd     = 1'b0;
      m_rp     = '0;
      m_stall  = 1'b1;
      m_tv     = 1'b0;
      m_tp     = '0;
      m_tl     = '0;
      m_tot    = 0;
      m_rx     = '0;
      m_sm     = 1'b0;
      for (int p = 0; p < num_ports; p++) begin
         m_cnt[p] = 0;
      end
   endtask

   task automatic model_clock(input logic [row_w-1:0] w);
      logic             rv;
      logic             rd;
      logic             tv;
      logic             dv;
      logic [pod_w-1:0] rp;
      logic [port_w-1:0] tp;
      logic [port_w-1:0] dp;
      logic [len_w-1:0] tl;
      logic [len_w-1:0] dl;
      bit               full;
      bit               empty;
      int               v;
      int               tot;
      {rv, rd, rp, tv, tp, tl, dv, dp, dl} = w;
      full  = (fl_q.size() == num_pods);
      empty = (fl_q.size() == 0);
      // stall is a level, seen one edge after init or a full list
      m_stall = in_init || full;
      // default slot passes through
      m_rv = rv;
      m_rd = rd;
      m_rp = rp;
      if (in_init) begin
         fl_q.push_back(init_ptr);
         init_ptr++;
         if (init_ptr == num_pods) begin
            in_init = 1'b0;
         end
      end else if (rv && rd && !full) begin
         // dirty pod goes back to the list
         fl_q.push_back(int'(rp));
         m_rv = 1'b0;
         m_rd = 1'b0;
      end else if (!rv && !empty) begin
         m_rv = 1'b1;
         m_rd = 1'b0;
         m_rp = pod_w'(fl_q.pop_front());
      end
      m_tv = tv;
      m_tp = tp;
      m_tl = tl;
      // watermarks use the counts before this edge
      for (int p = 0; p < num_ports; p++) begin
         if (m_cnt[p] >= wm_hi) begin
            m_rx[p] = 1'b1;
         end else if (m_cnt[p] <= wm_lo) begin
            m_rx[p] = 1'b0;
         end
      end
      m_sm = (m_tot >= gmm_pkg::sm_wm);
      tot  = 0;
      for (int p = 0; p < num_ports; p++) begin
         v = m_cnt[p];
         if (tv && int'(tp) == p) begin
            v += int'(tl);
         end
         if (dv && int'(dp) == p) begin
            v -= int'(dl);
         end
         // counters clamp at both ends
         if (v < 0) begin
            v = 0;
         end else if (v > cnt_max) begin
            v = cnt_max;
         end
         m_cnt[p] = v;
         tot += v;
      end
      m_tot = tot;
   endtask

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   task automatic check_val(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("ERROR %s %s expected %0d actual %0d", name, what, exp, act);
      end
   endtask

   task automatic check_all(input string name);
      check_val(name, "pod_ring_out_valid", m_rv, pod_ring_out_valid);
      // slot contents only matter on a valid slot
      if (m_rv) begin
         check_val(name, "pod_ring_out_dirty", m_rd, pod_ring_out_dirty);
         check_val(name, "pod_ring_out_ptr", m_rp, pod_ring_out_ptr);
      end
      check_val(name, "pod_ring_stall", m_stall, pod_ring_stall);
      check_val(name, "tag_out_valid", m_tv, tag_out_valid);
      if (m_tv) begin
         check_val(name, "tag_out_port", m_tp, tag_out_port);
         check_val(name, "tag_out_len", m_tl, tag_out_len);
      end
      for (int p = 0; p < num_ports; p++) begin
         check_val(name, $sformatf("port_cnt[%0d]", p), m_cnt[p],
                   DUT.u_occupancy_counter.port_cnt[p]);
      end
      check_val(name, "total_cnt", m_tot, DUT.u_occupancy_counter.total_cnt);
      check_val(name, "rx_wm", m_rx, rx_wm);
      check_val(name, "sm_wm", m_sm, sm_wm);
   endtask

   // drive on the falling edge, check at the next one
   task automatic run_step(input string name, input logic [row_w-1:0] w);
      {pod_ring_in_valid, pod_ring_in_dirty, pod_ring_in_ptr, tag_in_valid, tag_in_port,
       tag_in_len, deq_valid, deq_port, deq_len} = w;
      model_clock(w);
      @(negedge cclk);
      check_all(name);
   endtask

   // ----------------------------------------------------------------------
   // stimulus table
   // ----------------------------------------------------------------------

   task automatic build_table();
      logic [31:0] r;
      int          rets[4];
      rets = '{7, 3, 20, 11};
      // empty slots draw pods in list order, then stay empty
      // odd rows carry a stray dirty bit that an issued pod must drop
      for (int i = 0; i < num_pods + 2; i++) begin
         add_row("pod_issue", pack_row(0, i % 2, 0, 0, 0, 0, 0, 0, 0));
      end
      foreach (rets[i]) begin
         add_row("pod_return", pack_row(1, 1, rets[i], 0, 0, 0, 0, 0, 0));
      end
      for (int i = 0; i < 5; i++) begin
         add_row("pod_reissue", pack_row(0, 0, 0, 0, 0, 0, 0, 0, 0));
      end
      // 13 is odd so i*13 walks every pointer once
      for (int i = 0; i < num_pods; i++) begin
         add_row("pod_fill", pack_row(1, 1, (i * 13) % num_pods, 0, 0, 0, 0, 0, 0));
      end
      add_row("pod_full_pass", pack_row(1, 1, 9, 0, 0, 0, 0, 0, 0));
      add_row("pod_full_pass", pack_row(1, 1, 9, 0, 0, 0, 0, 0, 0));
      for (int i = 0; i < 3; i++) begin
         add_row("pod_drain", pack_row(0, 0, 0, 0, 0, 0, 0, 0, 0));
      end
      // random tags and dequeues, clean slots pass through
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         add_row("tag_repeat", pack_row(1, 0, r[4:0], r[5], r[7:6], r[11:8],
                                        r[12], r[14:13], r[18:15]));
      end
      for (int i = 0; i < 20; i++) begin
         for (int p = 0; p < num_ports; p++) begin
            add_row("occ_drain", pack_row(1, 0, 0, 0, 0, 0, 1, p, 15));
         end
      end
      for (int i = 0; i < 3; i++) begin
         add_row("occ_up", pack_row(1, 0, 0, 1, 1, 15, 0, 0, 0));
      end
      add_row("occ_set", pack_row(1, 0, 0, 1, 1, 3, 0, 0, 0));
      add_row("occ_pair", pack_row(1, 0, 0, 1, 1, 4, 1, 1, 10));
      add_row("occ_cross", pack_row(1, 0, 0, 1, 2, 6, 1, 1, 9));
      add_row("occ_hold", pack_row(1, 0, 0, 0, 0, 0, 0, 0, 0));
      add_row("occ_hold", pack_row(1, 0, 0, 0, 0, 0, 0, 0, 0));
      add_row("occ_clear", pack_row(1, 0, 0, 0, 0, 0, 1, 1, 1));
      add_row("occ_floor", pack_row(1, 0, 0, 0, 0, 0, 1, 3, 15));
      for (int i = 0; i < 18; i++) begin
         add_row("occ_ceiling", pack_row(1, 0, 0, 1, 0, 15, 0, 0, 0));
      end
      add_row("occ_ceiling_pair", pack_row(1, 0, 0, 1, 0, 15, 1, 0, 5));
      for (int i = 0; i < 17; i++) begin
         add_row("occ_down", pack_row(1, 0, 0, 0, 0, 0, 1, 0, 15));
      end
      for (int i = 0; i < 3; i++) begin
         add_row("occ_empty", pack_row(1, 0, 0, 0, 0, 0, 1, 1, 15));
      end
      add_row("occ_empty", pack_row(1, 0, 0, 0, 0, 0, 1, 2, 15));
      // spread enqueues so only the total crosses its mark
      for (int i = 0; i < 16; i++) begin
         add_row("sm_fill", pack_row(1, 0, 0, 1, i % num_ports, 8, 0, 0, 0));
      end
      for (int i = 0; i < 3; i++) begin
         add_row("sm_hold", pack_row(1, 0, 0, 0, 0, 0, 0, 0, 0));
      end
      for (int p = 0; p < num_ports; p++) begin
         add_row("sm_drain", pack_row(1, 0, 0, 0, 0, 0, 1, p, 8));
      end
      for (int i = 0; i < 3; i++) begin
         add_row("flush", pack_row(0, 0, 0, 0, 0, 0, 0, 0, 0));
      end
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------

   initial begin
      int waited;
      bit timed_out;
      timed_out         = 1'b0;
      rst_n             = 1'b0;
      pod_ring_in_valid = 1'b0;
      pod_ring_in_dirty = 1'b0;
      pod_ring_in_ptr   = '0;
      tag_in_valid      = 1'b0;
      tag_in_port       = '0;
      tag_in_len        = '0;
      deq_valid         = 1'b0;
      deq_port          = '0;
      deq_len           = '0;
      model_reset();
      build_table();
      repeat (10) @(negedge cclk);
      check_all("reset");
      rst_n = 1'b1;
      // idle slots until the list has room, bounded
      waited = 0;
      while (pod_ring_stall !== 1'b0 && waited < num_pods + 8) begin
         // dirty slots during the list load pass untouched
         if (in_init && waited % 2 == 1) begin
            run_step("init", pack_row(1, 1, waited, 0, 0, 0, 0, 0, 0));
         end else begin
            run_step("init", pack_row(0, 0, 0, 0, 0, 0, 0, 0, 0));
         end
         waited++;
      end
      assert (pod_ring_stall === 1'b0) else begin
         errors++;
         timed_out = 1'b1;
         $display("timeout: pod ring stall still high %0d cycles after reset", waited);
      end
      if (!timed_out) begin
         for (int i = 0; i < row_name.size(); i++) begin
            run_step(row_name[i], row_word[i]);
         end
      end
      $display("errors: %0d checks: %0d", errors, checks);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
gmm_pkg.sv
gmm_free_list.sv
gmm_pod_ring_fsm.sv
gmm_occupancy_counter.sv
gmm_watermark_cmp.sv
gmm_top.sv
tb_gmm_top.sv

// ==== Makefile ====
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_gmm_top
FLIST      = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
